// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_conv_pe
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1 || echo "Test failures found" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: conv_pe_top.sv
`timescale 1ns/1ns

module conv_pe_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              row_wr,
    input  conv_pkg::pixel_t  row_data [conv_pkg::row_len],
    input  logic              weight_wr,
    input  conv_pkg::filt_t   weight_filter,
    input  conv_pkg::krow_t   weight_row,
    input  conv_pkg::weight_t weight_taps [conv_pkg::k_size],
    output logic              busy,
    output logic              out_valid,
    output conv_pkg::col_t    out_col,
    output conv_pkg::acc_t    out_data [conv_pkg::n_filters]
);

    logic             win_valid;
    conv_pkg::col_t   win_col;
    conv_pkg::pixel_t window [conv_pkg::k_size][conv_pkg::k_size];

    row_buffer u_rows (
        .clk       (clk),
        .arst_n    (arst_n),
        .row_wr    (row_wr),
        .row_data  (row_data),
        .busy      (busy),
        .win_valid (win_valid),
        .win_col   (win_col),
        .window    (window)
    );

    // unit 0 also drives the valid and column shared by all filters
    kernel_mac #(.FILTER_ID(conv_pkg::filt_t'(0))) u_mac0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .weight_wr     (weight_wr),
        .weight_filter (weight_filter),
        .weight_row    (weight_row),
        .weight_taps   (weight_taps),
        .win_valid     (win_valid),
        .win_col       (win_col),
        .window        (window),
        .result_valid  (out_valid),
        .result_col    (out_col),
        .result        (out_data[0])
    );

    kernel_mac #(.FILTER_ID(conv_pkg::filt_t'(1))) u_mac1 (
        .clk           (clk),
        .arst_n        (arst_n),
        .weight_wr     (weight_wr),
        .weight_filter (weight_filter),
        .weight_row    (weight_row),
        .weight_taps   (weight_taps),
        .win_valid     (win_valid),
        .win_col       (win_col),
        .window        (window),
        .result_valid  (),
        .result_col    (),
        .result        (out_data[1])
    );

    kernel_mac #(.FILTER_ID(conv_pkg::filt_t'(2))) u_mac2 (
        .clk           (clk),
        .arst_n        (arst_n),
        .weight_wr     (weight_wr),
        .weight_filter (weight_filter),
        .weight_row    (weight_row),
        .weight_taps   (weight_taps),
        .win_valid     (win_valid),
        .win_col       (win_col),
        .window        (window),
        .result_valid  (),
        .result_col    (),
        .result        (out_data[2])
    );

endmodule

// File: conv_pkg.sv
package conv_pkg;

    // image geometry
    localparam int row_len = 32;
    localparam int k_size = 3;
    localparam int n_filters = 3;

    // window positions per sweep
    localparam int n_cols = row_len - k_size + 1;

    // datapath widths
    localparam int pix_w = 9;

    // nine 18-bit signed products need 4 extra bits of headroom
    localparam int acc_w = 22;

    typedef logic signed [pix_w-1:0] pixel_t;

    typedef logic signed [pix_w-1:0] weight_t;

    typedef logic signed [2*pix_w-1:0] prod_t;

    typedef logic signed [acc_w-1:0] acc_t;

    // column index into a row and window position
    typedef logic [$clog2(row_len)-1:0] col_t;

    typedef logic [$clog2(n_filters)-1:0] filt_t;

    typedef logic [$clog2(k_size)-1:0] krow_t;

endpackage

// File: kernel_mac.sv
`timescale 1ns/1ns

module kernel_mac #(
    parameter conv_pkg::filt_t FILTER_ID = '0
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              weight_wr,
    input  conv_pkg::filt_t   weight_filter,
    input  conv_pkg::krow_t   weight_row,
    input  conv_pkg::weight_t weight_taps [conv_pkg::k_size],
    input  logic              win_valid,
    input  conv_pkg::col_t    win_col,
    input  conv_pkg::pixel_t  window [conv_pkg::k_size][conv_pkg::k_size],
    output logic              result_valid,
    output conv_pkg::col_t    result_col,
    output conv_pkg::acc_t    result
);

    conv_pkg::weight_t weights [conv_pkg::k_size][conv_pkg::k_size];
    conv_pkg::prod_t   prods [conv_pkg::k_size][conv_pkg::k_size];
    logic              s1_valid;
    conv_pkg::col_t    s1_col;
    conv_pkg::acc_t    sum;
    logic              wr_hit;

    // only writes addressed to this filter and a real kernel row
    assign wr_hit = weight_wr && (weight_filter == FILTER_ID)
                    && (weight_row < 2'(conv_pkg::k_size));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < conv_pkg::k_size; r++) begin
                for (int t = 0; t < conv_pkg::k_size; t++) begin
                    weights[r][t] <= '0;
                end
            end
        end else if (wr_hit) begin
            weights[weight_row] <= weight_taps;
        end
    end

    // stage one registers nine signed products
    always_ff @(posedge clk) begin
        s1_col <= win_col;
        for (int r = 0; r < conv_pkg::k_size; r++) begin
            for (int t = 0; t < conv_pkg::k_size; t++) begin
                prods[r][t] <= window[r][t] * weights[r][t];
            end
        end
    end

    // adder tree with each product sign extended to the sum width
    always_comb begin
        sum = '0;
        for (int r = 0; r < conv_pkg::k_size; r++) begin
            for (int t = 0; t < conv_pkg::k_size; t++) begin
                sum = sum + conv_pkg::acc_t'(prods[r][t]);
            end
        end
    end

    // stage two registers the sum
    always_ff @(posedge clk) begin
        result_col <= s1_col;
        result <= sum;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid <= win_valid;
            result_valid <= s1_valid;
        end
    end

endmodule

// File: row_buffer.sv
`timescale 1ns/1ns

module row_buffer (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             row_wr,
    input  conv_pkg::pixel_t row_data [conv_pkg::row_len],
    output logic             busy,
    output logic             win_valid,
    output conv_pkg::col_t   win_col,
    output conv_pkg::pixel_t window [conv_pkg::k_size][conv_pkg::k_size]
);

    // row 0 is the oldest and row k_size-1 the newest
    conv_pkg::pixel_t rows [conv_pkg::k_size][conv_pkg::row_len];
    conv_pkg::pixel_t src_rows [conv_pkg::k_size][conv_pkg::row_len];

    logic [1:0]     row_cnt;
    logic           active;
    logic           accept;
    logic           start;
    logic           last;
    logic           load;
    conv_pkg::col_t load_col;

    // strobes during a sweep are dropped
    assign accept = row_wr && !active;

    // this strobe brings the held count to three
    assign start = accept && (row_cnt >= 2'(conv_pkg::k_size - 1));

    assign last = (win_col == conv_pkg::col_t'(conv_pkg::n_cols - 1));

    assign load = start || (active && !last);

    assign load_col = start ? '0 : conv_pkg::col_t'(win_col + 1'b1);

    // rows as they look after this edge so column 0 sees the new row
    always_comb begin
        if (accept) begin
            for (int r = 0; r < conv_pkg::k_size - 1; r++) begin
                src_rows[r] = rows[r + 1];
            end
            src_rows[conv_pkg::k_size - 1] = row_data;
        end else begin
            src_rows = rows;
        end
    end

    // row storage and window payload
    always_ff @(posedge clk) begin
        if (accept) begin
            rows <= src_rows;
        end
        if (load) begin
            for (int r = 0; r < conv_pkg::k_size; r++) begin
                for (int t = 0; t < conv_pkg::k_size; t++) begin
                    window[r][t] <= src_rows[r][conv_pkg::col_t'(int'(load_col) + t)];
                end
            end
        end
    end

    // held row count and sweep control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_cnt <= '0;
            active <= 1'b0;
            win_col <= '0;
        end else begin
            if (accept && (row_cnt < 2'(conv_pkg::k_size))) begin
                row_cnt <= row_cnt + 2'd1;
            end
            if (start) begin
                active <= 1'b1;
            end else if (active && last) begin
                active <= 1'b0;
            end
            if (load) begin
                win_col <= load_col;
            end
        end
    end

    assign busy = active;
    assign win_valid = active;

endmodule

// File: tb.f
conv_pkg.sv
row_buffer.sv
kernel_mac.sv
conv_pe_top.sv
tb_conv_pe_sva.sv
tb_conv_pe.sv

// File: tb_conv_pe.sv
`timescale 1ns/1ns

module tb_conv_pe;

    localparam int n_tests = 6;
    localparam int wait_limit = 100;

    logic              clk;
    logic              arst_n;
    logic              row_wr;
    conv_pkg::pixel_t  row_data [conv_pkg::row_len];
    logic              weight_wr;
    conv_pkg::filt_t   weight_filter;
    conv_pkg::krow_t   weight_row;
    conv_pkg::weight_t weight_taps [conv_pkg::k_size];
    logic              busy;
    logic              out_valid;
    conv_pkg::col_t    out_col;
    conv_pkg::acc_t    out_data [conv_pkg::n_filters];

    // reference model with row 0 as the oldest
    conv_pkg::pixel_t  m_rows [conv_pkg::k_size][conv_pkg::row_len];
    conv_pkg::weight_t m_w [conv_pkg::n_filters][conv_pkg::k_size][conv_pkg::k_size];
    conv_pkg::pixel_t  next_row [conv_pkg::row_len];
    conv_pkg::col_t    exp_col_q [$];
    conv_pkg::acc_t    exp_acc_q [$];
    int                m_cnt;
    int                errors;
    int                tests_failed;

    conv_pe_top UUT (
        .clk(clk), .arst_n(arst_n), .row_wr(row_wr), .row_data(row_data),
        .weight_wr(weight_wr), .weight_filter(weight_filter), .weight_row(weight_row),
        .weight_taps(weight_taps), .busy(busy), .out_valid(out_valid),
        .out_col(out_col), .out_data(out_data)
    );

    always begin
        #10 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_acc(string name, conv_pkg::acc_t got, conv_pkg::acc_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_col(string name, conv_pkg::col_t got, conv_pkg::col_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // result rule in plain integer arithmetic
    function automatic conv_pkg::acc_t model_sum(int f, int c);
        int s;
        s = 0;
        for (int r = 0; r < conv_pkg::k_size; r++) begin
            for (int t = 0; t < conv_pkg::k_size; t++) begin
                s += int'(m_w[f][r][t]) * int'(m_rows[r][c + t]);
            end
        end
        return conv_pkg::acc_t'(s);
    endfunction

    function automatic conv_pkg::pixel_t random_sample();
        case ($urandom_range(7, 0))
            0: return conv_pkg::pixel_t'(-256);
            1: return conv_pkg::pixel_t'(255);
            default: return conv_pkg::pixel_t'($urandom);
        endcase
    endfunction

    task automatic write_weights(int f, int r, int w0, int w1, int w2);
        weight_filter = conv_pkg::filt_t'(f);
        weight_row = conv_pkg::krow_t'(r);
        weight_taps[0] = conv_pkg::weight_t'(w0);
        weight_taps[1] = conv_pkg::weight_t'(w1);
        weight_taps[2] = conv_pkg::weight_t'(w2);
        weight_wr = 1'b1;
        tick();
        weight_wr = 1'b0;
        m_w[f][r] = weight_taps;
    endtask

    task automatic push_row(bit ignored);
        if (ignored && !busy) begin
            errors++;
            $display("DUT went idle before the strobe meant to be dropped");
        end
        row_data = next_row;
        row_wr = 1'b1;
        tick();
        row_wr = 1'b0;
        if (!ignored) begin
            for (int r = 0; r < conv_pkg::k_size - 1; r++) begin
                m_rows[r] = m_rows[r + 1];
            end
            m_rows[conv_pkg::k_size - 1] = next_row;
            if (m_cnt < conv_pkg::k_size) begin
                m_cnt++;
            end
            // three rows held means a full sweep follows
            if (m_cnt == conv_pkg::k_size) begin
                for (int c = 0; c < conv_pkg::n_cols; c++) begin
                    exp_col_q.push_back(conv_pkg::col_t'(c));
                    for (int f = 0; f < conv_pkg::n_filters; f++) begin
                        exp_acc_q.push_back(model_sum(f, c));
                    end
                end
            end
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < wait_limit) begin
            tick();
            n++;
        end
        if (busy) begin
            errors++;
            $display("busy never dropped after a sweep");
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_col_q.size() != 0 || busy) && n < wait_limit) begin
            tick();
            n++;
        end
        if (exp_col_q.size() != 0) begin
            errors++;
            $display("%0d expected results never appeared", exp_col_q.size());
            exp_col_q.delete();
            exp_acc_q.delete();
        end
    endtask

    task automatic end_test(string name, int err_before);
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("%-22s %s", name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    // results are sampled mid-cycle away from both edges
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (exp_col_q.size() == 0) begin
                errors++;
                $display("result for column %0d arrived with none expected", out_col);
            end else begin
                check_col("out_col", out_col, exp_col_q.pop_front());
                for (int f = 0; f < conv_pkg::n_filters; f++) begin
                    check_acc($sformatf("out_data[%0d]", f), out_data[f], exp_acc_q.pop_front());
                end
            end
        end
    end

    task automatic idle_after_reset();
        int e;
        e = errors;
        for (int c = 0; c < conv_pkg::row_len; c++) begin
            next_row[c] = conv_pkg::pixel_t'(c);
        end
        push_row(0);
        for (int c = 0; c < conv_pkg::row_len; c++) begin
            next_row[c] = conv_pkg::pixel_t'(c * 2 - 20);
        end
        push_row(0);
        repeat (40) begin
            if (busy !== 1'b0 || out_valid !== 1'b0) begin
                errors++;
                $display("busy or out_valid high with only two rows held");
            end
            tick();
        end
        end_test("reset and two rows", e);
    endtask

    task automatic identity_sweep();
        int e;
        e = errors;
        write_weights(0, 0, 0, 0, 0);
        write_weights(0, 1, 0, 1, 0);
        write_weights(0, 2, 0, 0, 0);
        write_weights(1, 0, 1, 0, 0);
        write_weights(1, 1, 0, 0, 0);
        write_weights(1, 2, 0, 0, 0);
        for (int r = 0; r < conv_pkg::k_size; r++) begin
            write_weights(2, r, 1, 1, 1);
        end
        for (int c = 0; c < conv_pkg::row_len; c++) begin
            next_row[c] = conv_pkg::pixel_t'(c * 3 - 40);
        end
        push_row(0);
        drain();
        end_test("identity kernels", e);
    endtask

    task automatic rotated_sweep();
        int e;
        e = errors;
        for (int c = 0; c < conv_pkg::row_len; c++) begin
            next_row[c] = conv_pkg::pixel_t'(100 - c * 7);
        end
        push_row(0);
        drain();
        end_test("fourth row rotates", e);
    endtask

    task automatic filter1_rewrite();
        int e;
        e = errors;
        write_weights(1, 2, -3, 4, 7);
        for (int c = 0; c < conv_pkg::row_len; c++) begin
            next_row[c] = conv_pkg::pixel_t'((c % 5) * 30 - 60);
        end
        push_row(0);
        drain();
        end_test("filter 1 rewrite", e);
    endtask

    task automatic dropped_strobe();
        int e;
        e = errors;
        for (int c = 0; c < conv_pkg::row_len; c++) begin
            next_row[c] = conv_pkg::pixel_t'(c * 5 - 90);
        end
        push_row(0);
        repeat (3) tick();
        next_row = '{default: conv_pkg::pixel_t'(255)};
        push_row(1);
        wait_idle();
        for (int c = 0; c < conv_pkg::row_len; c++) begin
            next_row[c] = conv_pkg::pixel_t'(-c * 4);
        end
        push_row(0);
        drain();
        end_test("strobe while busy", e);
    endtask

    task automatic random_sweeps();
        int e;
        e = errors;
        for (int f = 0; f < conv_pkg::n_filters; f++) begin
            for (int r = 0; r < conv_pkg::k_size; r++) begin
                write_weights(f, r, int'(random_sample()), int'(random_sample()),
                              int'(random_sample()));
            end
        end
        repeat (4) begin
            wait_idle();
            for (int c = 0; c < conv_pkg::row_len; c++) begin
                next_row[c] = random_sample();
            end
            push_row(0);
        end
        drain();
        end_test("random back-to-back", e);
    endtask

    initial begin
        void'($urandom(32'h39ad));
        clk = 1'b0;
        arst_n = 1'b0;
        row_wr = 1'b0;
        row_data = '{default: '0};
        weight_wr = 1'b0;
        weight_filter = '0;
        weight_row = '0;
        weight_taps = '{default: '0};
        m_rows = '{default: '0};
        m_w = '{default: '0};
        next_row = '{default: '0};
        m_cnt = 0;
        errors = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
        idle_after_reset();
        identity_sweep();
        rotated_sweep();
        filter1_rewrite();
        dropped_strobe();
        random_sweeps();
        errors += UUT.u_sva.fail_count;
        $display("tests %0d, failed %0d, errors %0d", n_tests, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (n_tests * 200) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: tb_conv_pe_sva.sv
`timescale 1ns/1ns

module conv_pe_sva (
    input logic           clk,
    input logic           arst_n,
    input logic           busy,
    input logic           out_valid,
    input conv_pkg::col_t out_col
);

    int fail_quiet = 0;
    int fail_len = 0;
    int fail_col = 0;
    int fail_lag = 0;
    int fail_count;
    int busy_len;

    assign fail_count = fail_quiet + fail_len + fail_col + fail_lag;

    // length of the current busy run
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_len <= 0;
        end else if (busy) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !out_valid ##1 !out_valid ##1 !out_valid)
        else begin
            $error("out_valid high right after reset release");
            fail_quiet++;
        end

    sweep_length: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> (busy_len == conv_pkg::n_cols))
        else begin
            $error("busy lasted %0d cycles", busy_len);
            fail_len++;
        end

    col_steps: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && $past(out_valid)) |-> (out_col == conv_pkg::col_t'($past(out_col) + 1'b1)))
        else begin
            $error("out_col skipped within a burst");
            fail_col++;
        end

    // two pipeline stages between window and result
    valid_lag: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(busy, 2))
        else begin
            $error("out_valid does not trail busy by two cycles");
            fail_lag++;
        end

endmodule

bind conv_pe_top conv_pe_sva u_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .busy      (busy),
    .out_valid (out_valid),
    .out_col   (out_col)
);
